// File: verilog.f
verilog/gcu_pkg.sv
verilog/gcu_layer_ram.sv
verilog/gcu_bus_slave.sv
verilog/gcu_scroll_regs.sv
verilog/gcu_vram_access.sv
verilog/gcu_top.sv
bench/gcu_tb.sv

// File: Bender.yml
package:
  name: gcu

sources:
  - files:
      - verilog/gcu_pkg.sv
      - verilog/gcu_layer_ram.sv
      - verilog/gcu_bus_slave.sv
      - verilog/gcu_scroll_regs.sv
      - verilog/gcu_vram_access.sv
      - verilog/gcu_top.sv
  - target: test
    files:
      - bench/gcu_tb.sv

// File: bench/gcu_tb.sv
// gcu_top testbench with clock, reset, LFSR stimulus, bus tasks, reference model and checks
`timescale 1ns/1ps

module gcu_tb;
    import gcu_pkg::*;

    logic               CLK96;
    logic               RESET96;
    wb_req_t            bus_req;
    wb_rsp_t            bus_rsp;
    logic               flip_x;
    logic               flip_y;
    logic [8:0]         v;
    logic               vint_n;
    scroll_set_t        scroll;
    logic [SCR_AW-1:0]  scr0_addr;
    logic [SCR_AW-1:0]  scr1_addr;
    logic [SCR_AW-1:0]  scr2_addr;
    logic [SPR_AW-1:0]  spr_addr;
    logic [DATA_W-1:0]  scr0_data;
    logic [DATA_W-1:0]  scr1_data;
    logic [DATA_W-1:0]  scr2_data;
    logic [DATA_W-1:0]  spr_data;

    logic [31:0]        lfsr_state = 32'h4d35_8983;
    int                 errors = 0;
    int                 checks = 0;
    logic               timed_out = 1'b0;
    logic [DATA_W-1:0]  rd_q;
    logic [7:0]         sel_req;

    // reference model
    logic [DATA_W-1:0]  ptr_m;
    logic [7:0]         sel_m;
    layer_scroll_t      lay_m [4];
    logic [DATA_W-1:0]  vram_m [int];
    logic [VRAM_AW-1:0] bases [4] = '{SCR0_BASE, SCR1_BASE, SCR2_BASE, SPR_BASE};

    gcu_top #(.VINT_LINE(9'h0E6)) dut_i (.*);

    initial CLK96 = 1'b0;
    always #10 CLK96 = ~CLK96;

    // register number carried by a select request
    assign sel_req = bus_req.dat[7:0] & REG_SEL_MASK;

    ack_pulse: assert property (@(posedge CLK96) disable iff (RESET96)
        bus_rsp.ack |=> !bus_rsp.ack)
    else begin
        errors++;
        $display("ack stayed high for more than one cycle");
    end

    // the interrupt line must drop right after the programmed scanline
    vint_fall: assert property (@(posedge CLK96) disable iff (RESET96)
        (v == 9'h0E6) |=> !vint_n)
    else begin
        errors++;
        $display("vint_n did not fall one cycle after scanline 0xE6");
    end

    // a release select raises the interrupt line on the cycle after its op
    vint_release: assert property (@(posedge CLK96) disable iff (RESET96)
        ($rose(bus_req.stb) && bus_req.we && bus_req.adr == ADR_REG_SEL &&
         (sel_req == 8'h0E || sel_req == 8'h0F || sel_req == 8'h8F)) |-> ##2 vint_n)
    else begin
        errors++;
        $display("vint_n did not rise one cycle after a release select");
    end

    // galois form with one step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
            r = {r[14:0], b};
        end
        return r;
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        value_ok: assert (got === exp)
        else begin
            errors++;
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_scroll();
        for (int i = 0; i < 4; i++) begin
            check_val($sformatf("scroll layer %0d", i), 64'(scroll[135 - 34*i -: 34]),
                      64'(lay_m[i]));
        end
    endtask

    // one classic cycle with ack latency counted from the first sampling edge
    task automatic wb_access(input logic [2:0] adr, input logic we, input logic [15:0] dat,
                             input int lat_exp);
        int n;
        n = 0;
        bus_req = '{adr: adr, dat: dat, we: we, cyc: 1'b1, stb: 1'b1};
        do begin
            @(posedge CLK96);
            #2;
            n++;
        end while (!bus_rsp.ack && n < 16);
        if (!bus_rsp.ack) begin
            errors++;
            $display("timeout waiting for ack on bus address %0d", adr);
            timed_out = 1'b1;
        end else begin
            check_val("ack latency", 64'(n - 1), 64'(lat_exp));
            rd_q = bus_rsp.dat;
        end
        bus_req = '0;
        @(posedge CLK96);
        #2;
    endtask

    task automatic sel_reg(input logic [7:0] num);
        wb_access(ADR_REG_SEL, 1'b1, {8'h00, num}, 2);
        sel_m = num & REG_SEL_MASK;
    endtask

    task automatic wr_reg(input logic [15:0] dat);
        int l;
        l = int'(sel_m[2:1]);
        wb_access(ADR_REG_DATA, 1'b1, dat, 2);
        if (sel_m <= 8'h07 || (sel_m >= 8'h80 && sel_m <= 8'h87)) begin
            if (sel_m[0]) begin
                lay_m[l].y      = dat;
                lay_m[l].flip_y = sel_m[7] ? (lay_m[l].flip_y | flip_y)
                                           : (lay_m[l].flip_y & ~flip_y);
            end else begin
                lay_m[l].x      = dat;
                lay_m[l].flip_x = sel_m[7] ? (lay_m[l].flip_x | flip_x)
                                           : (lay_m[l].flip_x & ~flip_x);
            end
        end
        check_scroll();
    endtask

    task automatic set_ptr(input logic [15:0] p);
        wb_access(ADR_RAM_PTR, 1'b1, p, 2);
        ptr_m = p;
    endtask

    task automatic wr_ram(input logic [15:0] dat);
        wb_access(ADR_RAM_DATA, 1'b1, dat, 3);
        vram_m[int'(ptr_m[VRAM_AW-1:0])] = dat;
        ptr_m++;
    endtask

    task automatic rd_ram(input logic next);
        logic [VRAM_AW-1:0] a;
        a = ptr_m[VRAM_AW-1:0] + VRAM_AW'(next);
        wb_access(next ? ADR_RAM_NEXT : ADR_RAM_DATA, 1'b0, 16'h0000, 4);
        check_val("bus_rsp.dat", 64'(rd_q), 64'(vram_m[int'(a)]));
    endtask

    // all four renderer ports read at the same offset after one cycle
    task automatic check_layers(input logic [9:0] off);
        scr0_addr = SCR_AW'(off);
        scr1_addr = SCR_AW'(off);
        scr2_addr = SCR_AW'(off);
        spr_addr  = off;
        @(posedge CLK96);
        #2;
        check_val("scr0_data", 64'(scr0_data), 64'(vram_m[int'(SCR0_BASE) + int'(off)]));
        check_val("scr1_data", 64'(scr1_data), 64'(vram_m[int'(SCR1_BASE) + int'(off)]));
        check_val("scr2_data", 64'(scr2_data), 64'(vram_m[int'(SCR2_BASE) + int'(off)]));
        check_val("spr_data", 64'(spr_data), 64'(vram_m[int'(SPR_BASE) + int'(off)]));
    endtask

    task automatic run_tests();
        logic [7:0] ign [4] = '{8'h08, 8'h3D, 8'h8A, 8'hFF};
        logic [7:0] clr [3] = '{8'h0E, 8'h0F, 8'h8F};
        logic [9:0] off;
        int         r;
        check_val("vint_n", 64'(vint_n), 64'd1);
        check_scroll();
        // every register under both pin values in set and clear modes
        for (int p = 0; p < 4; p++) begin
            flip_x = p[0];
            flip_y = p[1];
            for (int m = 0; m < 16; m++) begin
                sel_reg({m[3], 4'h0, m[2:0]});
                wr_reg(rand_bits(16));
            end
            for (int i = 0; i < 4; i++) begin
                sel_reg(ign[i]);
                wr_reg(rand_bits(16));
            end
        end
        // ascending then descending region order so a stray write shows in either pass
        for (int pass = 0; pass < 2; pass++) begin
            off = 10'(rand_bits(9));
            for (int k = 0; k < 4; k++) begin
                r = (pass == 0) ? k : 3 - k;
                set_ptr(16'(bases[r]) + 16'(off));
                for (int w = 0; w < 4; w++) begin
                    wr_ram(rand_bits(16));
                end
                for (int w = 0; w < 4; w++) begin
                    set_ptr(16'(bases[r]) + 16'(off) + 16'(w));
                    rd_ram(1'b0);
                end
                set_ptr(16'(bases[r]) + 16'(off));
                rd_ram(1'b1);
                rd_ram(1'b1);
            end
            for (int w = 0; w < 4; w++) begin
                check_layers(off + 10'(w));
            end
        end
        // accesses with no effect
        wb_access(ADR_RAM_NEXT, 1'b1, rand_bits(16), 2);
        wb_access(3'd6, 1'b1, rand_bits(16), 2);
        rd_ram(1'b0);
        wb_access(ADR_REG_SEL, 1'b0, 16'h0000, 2);
        check_val("bus_rsp.dat", 64'(rd_q), 64'd0);
        // interrupt raise and release
        for (int i = 0; i < 3; i++) begin
            v = 9'h0E6;
            @(posedge CLK96);
            #2;
            v = 9'h000;
            check_val("vint_n", 64'(vint_n), 64'd0);
            sel_reg(8'h05);
            check_val("vint_n", 64'(vint_n), 64'd0);
            sel_reg(clr[i]);
            check_val("vint_n", 64'(vint_n), 64'd1);
        end
    endtask

    task automatic finish_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        bus_req   = '0;
        flip_x    = 1'b0;
        flip_y    = 1'b1;
        v         = 9'h000;
        scr0_addr = '0;
        scr1_addr = '0;
        scr2_addr = '0;
        spr_addr  = '0;
        RESET96   = 1'b1;
        ptr_m     = '0;
        sel_m     = 8'hFF;
        for (int i = 0; i < 4; i++) begin
            lay_m[i] = '{x: '0, y: '0, flip_x: ~flip_x, flip_y: ~flip_y};
        end
        repeat (10) @(posedge CLK96);
        #2;
        RESET96 = 1'b0;
        fork
            run_tests();
            wait (timed_out);
        join_any
        disable fork;
        finish_run();
    end

endmodule

// File: verilog/gcu_top.sv
// top level: bus slave, scroll registers, VRAM access engine and the five VRAM copies
`timescale 1ns/1ps

module gcu_top #(
    parameter logic [8:0] VINT_LINE = 9'h0E6
) (
    input  logic                         CLK96,
    input  logic                         RESET96,
    input  gcu_pkg::wb_req_t             bus_req,
    output gcu_pkg::wb_rsp_t             bus_rsp,
    input  logic                         flip_x,
    input  logic                         flip_y,
    input  logic [8:0]                   v,
    output logic                         vint_n,
    output gcu_pkg::scroll_set_t         scroll,
    input  logic [gcu_pkg::SCR_AW-1:0]   scr0_addr,
    input  logic [gcu_pkg::SCR_AW-1:0]   scr1_addr,
    input  logic [gcu_pkg::SCR_AW-1:0]   scr2_addr,
    input  logic [gcu_pkg::SPR_AW-1:0]   spr_addr,
    output logic [gcu_pkg::DATA_W-1:0]   scr0_data,
    output logic [gcu_pkg::DATA_W-1:0]   scr1_data,
    output logic [gcu_pkg::DATA_W-1:0]   scr2_data,
    output logic [gcu_pkg::DATA_W-1:0]   spr_data
);
    import gcu_pkg::*;

    gcu_op_t            op;
    vram_wr_t           vram_wr;
    logic               reg_done;
    logic               reg_done_scr;
    logic               reg_done_ptr;
    logic               ram_done;
    logic [DATA_W-1:0]  rd_data;
    logic [DATA_W-1:0]  main_q;
    logic [VRAM_AW-1:0] main_rd_addr;

    // the two register paths never complete on the same cycle
    assign reg_done = reg_done_scr | reg_done_ptr;

    gcu_bus_slave u_bus_slave (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .bus_req  (bus_req),
        .reg_done (reg_done),
        .ram_done (ram_done),
        .rd_data  (rd_data),
        .bus_rsp  (bus_rsp),
        .op       (op)
    );

    gcu_scroll_regs #(.VINT_LINE(VINT_LINE)) u_scroll_regs (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .op       (op),
        .flip_x   (flip_x),
        .flip_y   (flip_y),
        .v        (v),
        .scroll   (scroll),
        .reg_done (reg_done_scr),
        .vint_n   (vint_n)
    );

    gcu_vram_access u_vram_access (
        .CLK96        (CLK96),
        .RESET96      (RESET96),
        .op           (op),
        .main_q       (main_q),
        .vram_wr      (vram_wr),
        .main_rd_addr (main_rd_addr),
        .ram_done     (ram_done),
        .rd_data      (rd_data),
        .reg_done_ptr (reg_done_ptr)
    );

    // full copy for CPU reads, split copies for the renderer
    gcu_layer_ram #(.AW(VRAM_AW), .BASE(SCR0_BASE)) u_main_ram (
        .CLK96(CLK96), .wr(vram_wr), .rd_addr(main_rd_addr), .rd_data(main_q)
    );

    gcu_layer_ram #(.AW(SCR_AW), .BASE(SCR0_BASE)) u_scr0_ram (
        .CLK96(CLK96), .wr(vram_wr), .rd_addr(scr0_addr), .rd_data(scr0_data)
    );

    gcu_layer_ram #(.AW(SCR_AW), .BASE(SCR1_BASE)) u_scr1_ram (
        .CLK96(CLK96), .wr(vram_wr), .rd_addr(scr1_addr), .rd_data(scr1_data)
    );

    gcu_layer_ram #(.AW(SCR_AW), .BASE(SCR2_BASE)) u_scr2_ram (
        .CLK96(CLK96), .wr(vram_wr), .rd_addr(scr2_addr), .rd_data(scr2_data)
    );

    gcu_layer_ram #(.AW(SPR_AW), .BASE(SPR_BASE)) u_spr_ram (
        .CLK96(CLK96), .wr(vram_wr), .rd_addr(spr_addr), .rd_data(spr_data)
    );

endmodule

// File: verilog/gcu_vram_access.sv
// VRAM pointer, write and read sequencing, and the write stream to the layer RAMs
`timescale 1ns/1ps

module gcu_vram_access (
    input  logic                         CLK96,
    input  logic                         RESET96,
    input  gcu_pkg::gcu_op_t             op,
    input  logic [gcu_pkg::DATA_W-1:0]   main_q,
    output gcu_pkg::vram_wr_t            vram_wr,
    output logic [gcu_pkg::VRAM_AW-1:0]  main_rd_addr,
    output logic                         ram_done,
    output logic [gcu_pkg::DATA_W-1:0]   rd_data,
    output logic                         reg_done_ptr
);
    import gcu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_RD_WAIT,
        ST_RD_CAP
    } state_e;

    state_e             state;
    logic [DATA_W-1:0]  ptr;
    logic [VRAM_AW-1:0] ptr_addr;
    logic               rd_next;
    logic               start_wr;
    logic               start_rd;
    logic [VRAM_AW-1:0] wr_addr;
    logic [DATA_W-1:0]  wr_data;
    logic               wr_we;

    // pointer is 16 bits wide, VRAM only sees the low 14
    assign ptr_addr = ptr[VRAM_AW-1:0];
    assign rd_next  = (op.kind == OP_RD_RAM_NEXT);
    assign start_wr = (state == ST_IDLE) && (op.kind == OP_WR_RAM);
    assign start_rd = (state == ST_IDLE) && (op.kind == OP_RD_RAM || rd_next);

    assign vram_wr = '{addr: wr_addr, data: wr_data, we: wr_we};

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state        <= ST_IDLE;
            ptr          <= '0;
            wr_we        <= 1'b0;
            ram_done     <= 1'b0;
            reg_done_ptr <= 1'b0;
        end else begin
            ram_done     <= 1'b0;
            reg_done_ptr <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (op.kind == OP_SET_PTR) begin
                        ptr          <= op.data;
                        reg_done_ptr <= 1'b1;
                    end else if (start_wr) begin
                        wr_we <= 1'b1;
                        state <= ST_WRITE;
                    end else if (start_rd) begin
                        state <= ST_RD_WAIT;
                    end
                end
                // write strobe lasts one cycle, pointer moves after it
                ST_WRITE: begin
                    wr_we    <= 1'b0;
                    ptr      <= ptr + 16'd1;
                    ram_done <= 1'b1;
                    state    <= ST_IDLE;
                end
                // main RAM samples the address here
                ST_RD_WAIT: begin
                    state <= ST_RD_CAP;
                end
                ST_RD_CAP: begin
                    ram_done <= 1'b1;
                    state    <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // address and data registers
    always_ff @(posedge CLK96) begin
        if (start_wr) begin
            wr_addr <= ptr_addr;
            wr_data <= op.data;
        end
        // read next wraps inside the 14-bit space
        if (start_rd) begin
            main_rd_addr <= ptr_addr + VRAM_AW'(rd_next);
        end
        if (state == ST_RD_CAP) begin
            rd_data <= main_q;
        end
    end

endmodule

// File: verilog/gcu_scroll_regs.sv
// register select, eight scroll registers with sticky flip bits, vertical interrupt
`timescale 1ns/1ps

module gcu_scroll_regs #(
    parameter logic [8:0] VINT_LINE = 9'h0E6
) (
    input  logic                   CLK96,
    input  logic                   RESET96,
    input  gcu_pkg::gcu_op_t       op,
    input  logic                   flip_x,
    input  logic                   flip_y,
    input  logic [8:0]             v,
    output gcu_pkg::scroll_set_t   scroll,
    output logic                   reg_done,
    output logic                   vint_n
);
    import gcu_pkg::*;

    logic [7:0]    sel_num;
    logic [7:0]    sel_next;
    logic          sel_valid;
    logic [2:0]    idx;
    logic [1:0]    layer;
    logic          vint_clear;
    layer_scroll_t lay [4];

    // set mode ORs the pin in, clear mode masks it out
    function automatic logic sticky_flip(input logic cur, input logic pin, input logic set);
        return set ? (cur | pin) : (cur & ~pin);
    endfunction

    assign sel_next = op.data[7:0] & REG_SEL_MASK;

    // only 0x00-0x07 and 0x80-0x87 hit a scroll register
    assign sel_valid = (sel_num[6:3] == 4'd0);
    assign idx       = sel_num[2:0];

    // order is bg, fg, txt, spr with x before y
    assign layer = idx[2:1];

    // interrupt acknowledge registers
    assign vint_clear = (op.kind == OP_SEL_REG) &&
                        (sel_next == 8'h0E || sel_next == 8'h0F || sel_next == 8'h8F);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sel_num <= 8'hFF;
            for (int i = 0; i < 4; i++) begin
                lay[i].x      <= '0;
                lay[i].y      <= '0;
                lay[i].flip_x <= ~flip_x;
                lay[i].flip_y <= ~flip_y;
            end
        end else if (op.kind == OP_SEL_REG) begin
            sel_num <= sel_next;
        end else if (op.kind == OP_WR_REG && sel_valid) begin
            if (idx[0]) begin
                lay[layer].y      <= op.data;
                lay[layer].flip_y <= sticky_flip(lay[layer].flip_y, flip_y, sel_num[7]);
            end else begin
                // each layer keeps its own x flip, sprite included
                lay[layer].x      <= op.data;
                lay[layer].flip_x <= sticky_flip(lay[layer].flip_x, flip_x, sel_num[7]);
            end
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            reg_done <= 1'b0;
            vint_n   <= 1'b1;
        end else begin
            reg_done <= (op.kind == OP_SEL_REG) || (op.kind == OP_WR_REG);
            // acknowledge wins over a new assertion on the same cycle
            if (vint_clear) begin
                vint_n <= 1'b1;
            end else if (v == VINT_LINE) begin
                vint_n <= 1'b0;
            end
        end
    end

    assign scroll = '{bg: lay[0], fg: lay[1], txt: lay[2], spr: lay[3]};

endmodule

// File: verilog/gcu_bus_slave.sv
// wishbone classic slave: request decode, one-cycle op issue, ack and read data return
`timescale 1ns/1ps

module gcu_bus_slave (
    input  logic                        CLK96,
    input  logic                        RESET96,
    input  gcu_pkg::wb_req_t            bus_req,
    input  logic                        reg_done,
    input  logic                        ram_done,
    input  logic [gcu_pkg::DATA_W-1:0]  rd_data,
    output gcu_pkg::wb_rsp_t            bus_rsp,
    output gcu_pkg::gcu_op_t            op
);
    import gcu_pkg::*;

    logic    busy;
    logic    acked;
    logic    is_read;
    logic    nop_pend;
    logic    nop_done;
    logic    accept;
    gcu_op_e kind;

    // one request at a time, next one only after stb has dropped
    assign accept = bus_req.cyc && bus_req.stb && !busy;

    // address and direction to operation kind
    always_comb begin
        kind = OP_NONE;
        case (bus_req.adr)
            ADR_REG_SEL:  if (bus_req.we) kind = OP_SEL_REG;
            ADR_REG_DATA: if (bus_req.we) kind = OP_WR_REG;
            ADR_RAM_PTR:  if (bus_req.we) kind = OP_SET_PTR;
            ADR_RAM_DATA: kind = bus_req.we ? OP_WR_RAM : OP_RD_RAM;
            ADR_RAM_NEXT: if (!bus_req.we) kind = OP_RD_RAM_NEXT;
            default:      kind = OP_NONE;
        endcase
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            busy     <= 1'b0;
            acked    <= 1'b0;
            is_read  <= 1'b0;
            nop_pend <= 1'b0;
            nop_done <= 1'b0;
            op       <= '{kind: OP_NONE, data: '0};
            bus_rsp  <= '{dat: '0, ack: 1'b0};
        end else begin
            op.kind     <= OP_NONE;
            nop_pend    <= 1'b0;
            // ignored accesses finish on the same cycle as register ops
            nop_done    <= nop_pend;
            bus_rsp.ack <= 1'b0;

            if (accept) begin
                busy     <= 1'b1;
                acked    <= 1'b0;
                is_read  <= !bus_req.we &&
                            (bus_req.adr == ADR_RAM_DATA || bus_req.adr == ADR_RAM_NEXT);
                op       <= '{kind: kind, data: bus_req.dat};
                nop_pend <= (kind == OP_NONE);
            end

            if (busy && !acked && (reg_done || ram_done || nop_done)) begin
                bus_rsp.ack <= 1'b1;
                bus_rsp.dat <= is_read ? rd_data : '0;
                acked       <= 1'b1;
            end

            // master releases stb after seeing ack
            if (busy && acked && !bus_req.stb) begin
                busy  <= 1'b0;
                acked <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/gcu_layer_ram.sv
// dual-port RAM fed by the VRAM write stream, one synchronous read port
`timescale 1ns/1ps

module gcu_layer_ram #(
    parameter int                            AW   = 11,
    parameter logic [gcu_pkg::VRAM_AW-1:0]   BASE = '0
) (
    input  logic                         CLK96,
    input  gcu_pkg::vram_wr_t            wr,
    input  logic [AW-1:0]                rd_addr,
    output logic [gcu_pkg::DATA_W-1:0]   rd_data
);
    import gcu_pkg::*;

    // first word past the region, may exceed the 14-bit space
    localparam int LIMIT = int'(BASE) + (2 ** AW);

    logic [DATA_W-1:0]  mem [2**AW];
    logic [VRAM_AW-1:0] offset;
    logic               in_region;

    assign offset    = wr.addr - BASE;
    assign in_region = (int'(wr.addr) >= int'(BASE)) && (int'(wr.addr) < LIMIT);

    always_ff @(posedge CLK96) begin
        if (wr.we && in_region) begin
            mem[offset[AW-1:0]] <= wr.data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verilog/gcu_pkg.sv
// widths, bus address map, VRAM region bounds and the bus, operation and scroll structs
package gcu_pkg;

    // bus and memory widths
    localparam int DATA_W  = 16;
    localparam int VRAM_AW = 14;
    localparam int SCR_AW  = 11;
    localparam int SPR_AW  = 10;

    // wishbone word addresses
    localparam logic [2:0] ADR_REG_SEL  = 3'd0;
    localparam logic [2:0] ADR_REG_DATA = 3'd1;
    localparam logic [2:0] ADR_RAM_PTR  = 3'd2;
    localparam logic [2:0] ADR_RAM_DATA = 3'd3;
    localparam logic [2:0] ADR_RAM_NEXT = 3'd4;

    // VRAM layout, one region per renderer layer
    localparam logic [VRAM_AW-1:0] SCR0_BASE = 14'h0000;
    localparam logic [VRAM_AW-1:0] SCR1_BASE = 14'h0800;
    localparam logic [VRAM_AW-1:0] SCR2_BASE = 14'h1000;
    localparam logic [VRAM_AW-1:0] SPR_BASE  = 14'h1800;
    localparam logic [VRAM_AW-1:0] SPR_END   = 14'h1C00;

    // bit 7 picks the flip rule, low nibble picks the register
    localparam logic [7:0] REG_SEL_MASK = 8'h8F;

    typedef struct packed {
        logic [2:0]        adr;
        logic [DATA_W-1:0] dat;
        logic              we;
        logic              cyc;
        logic              stb;
    } wb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] dat;
        logic              ack;
    } wb_rsp_t;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_SEL_REG,
        OP_WR_REG,
        OP_SET_PTR,
        OP_WR_RAM,
        OP_RD_RAM,
        OP_RD_RAM_NEXT
    } gcu_op_e;

    typedef struct packed {
        gcu_op_e           kind;
        logic [DATA_W-1:0] data;
    } gcu_op_t;

    // one layer as seen by the renderer
    typedef struct packed {
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        logic              flip_x;
        logic              flip_y;
    } layer_scroll_t;

    typedef struct packed {
        layer_scroll_t bg;
        layer_scroll_t fg;
        layer_scroll_t txt;
        layer_scroll_t spr;
    } scroll_set_t;

    typedef struct packed {
        logic [VRAM_AW-1:0] addr;
        logic [DATA_W-1:0]  data;
        logic               we;
    } vram_wr_t;

endpackage
